// File: hw/cache_pkg.sv
package cache_pkg;

	parameter int addr_w = 12;
	parameter int data_w = 32;
	parameter int index_w = 3;
	parameter int tag_w = 5;
	parameter int word_sel_w = 2;
	parameter int byte_off_w = addr_w - index_w - tag_w - word_sel_w; // byte within word
	parameter int num_lines = 8;
	parameter int words_per_line = 4;

	typedef enum logic [1:0] {
		st_idle,  // accesses served
		st_fill,  // read miss waiting on memory
		st_write  // write-through waiting on memory
	} cache_state_t;

	// address fields, top to bottom: index, tag, word, byte
	function automatic logic [index_w-1:0] addr_index(input logic [addr_w-1:0] a);
		return a[addr_w-1 -: index_w];
	endfunction

	function automatic logic [tag_w-1:0] addr_tag(input logic [addr_w-1:0] a);
		return a[byte_off_w + word_sel_w +: tag_w];
	endfunction

	function automatic logic [word_sel_w-1:0] addr_word(input logic [addr_w-1:0] a);
		return a[byte_off_w +: word_sel_w];
	endfunction

endpackage

// File: hw/cache_tag_store.sv
`timescale 1ns/1ps

module cache_tag_store (
	input  logic                             clk,
	input  logic                             rst,
	input  logic [cache_pkg::index_w-1:0]    lookup_index,
	input  logic [cache_pkg::tag_w-1:0]      lookup_tag,
	input  logic [cache_pkg::word_sel_w-1:0] lookup_word,
	output logic                             hit,
	input  logic                             fill,
	input  logic [cache_pkg::index_w-1:0]    fill_index,
	input  logic [cache_pkg::tag_w-1:0]      fill_tag,
	input  logic [cache_pkg::word_sel_w-1:0] fill_word
);
	import cache_pkg::*;

	logic [tag_w-1:0]          tags  [num_lines];
	logic [words_per_line-1:0] valid [num_lines];
	logic [words_per_line-1:0] fill_bit;
	logic                      tag_same;

	assign fill_bit = words_per_line'(1) << fill_word;
	assign tag_same = (tags[fill_index] == fill_tag);

	assign hit = valid[lookup_index][lookup_word] && (tags[lookup_index] == lookup_tag);

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < num_lines; i++) begin
				valid[i] <= '0;
			end
		end else if (fill) begin
			if (tag_same) begin
				valid[fill_index] <= valid[fill_index] | fill_bit; // add one more word
			end else begin
				valid[fill_index] <= fill_bit; // new owner, old words gone
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fill) begin
			tags[fill_index] <= fill_tag;
		end
	end

	// all lines start empty, so nothing can hit before the first fill
	a_no_hit_after_reset: assert property (@(posedge clk) $fell(rst) |-> !hit)
		else $error("tag store reported a hit right after reset");

endmodule

// File: hw/cache_data_store.sv
`timescale 1ns/1ps

module cache_data_store (
	input  logic                             clk,
	input  logic [cache_pkg::index_w-1:0]    rd_index,
	input  logic [cache_pkg::word_sel_w-1:0] rd_word,
	output logic [cache_pkg::data_w-1:0]     rdata,
	input  logic                             wr_en,
	input  logic [cache_pkg::index_w-1:0]    wr_index,
	input  logic [cache_pkg::word_sel_w-1:0] wr_word,
	input  logic [cache_pkg::data_w-1:0]     wr_data
);
	import cache_pkg::*;

	// one bank per word position in the line
	logic [data_w-1:0] bank0 [num_lines];
	logic [data_w-1:0] bank1 [num_lines];
	logic [data_w-1:0] bank2 [num_lines];
	logic [data_w-1:0] bank3 [num_lines];

	always_ff @(posedge clk) begin
		if (wr_en) begin // fill or write hit
			case (wr_word)
				2'd0: begin
					bank0[wr_index] <= wr_data;
				end
				2'd1: begin
					bank1[wr_index] <= wr_data;
				end
				2'd2: begin
					bank2[wr_index] <= wr_data;
				end
				default: begin
					bank3[wr_index] <= wr_data;
				end
			endcase
		end
	end

	always_comb begin
		case (rd_word) // word select
			2'd0: begin
				rdata = bank0[rd_index];
			end
			2'd1: begin
				rdata = bank1[rd_index];
			end
			2'd2: begin
				rdata = bank2[rd_index];
			end
			default: begin
				rdata = bank3[rd_index];
			end
		endcase
	end

endmodule

// File: hw/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             req,
	input  logic                             we,
	input  logic [cache_pkg::addr_w-1:0]     addr,
	input  logic [cache_pkg::data_w-1:0]     wdata,
	input  logic                             hit,
	output logic                             stall,
	output logic                             fill,
	output logic [cache_pkg::index_w-1:0]    fill_index,
	output logic [cache_pkg::tag_w-1:0]      fill_tag,
	output logic [cache_pkg::word_sel_w-1:0] fill_word,
	output logic                             wr_en,
	output logic [cache_pkg::index_w-1:0]    wr_index,
	output logic [cache_pkg::word_sel_w-1:0] wr_word,
	output logic [cache_pkg::data_w-1:0]     wr_data,
	output logic                             mem_req,
	output logic                             mem_we,
	output logic [cache_pkg::addr_w-1:0]     mem_addr,
	output logic [cache_pkg::data_w-1:0]     mem_wdata,
	input  logic                             mem_ack,
	input  logic [cache_pkg::data_w-1:0]     mem_rdata
);
	import cache_pkg::*;

	cache_state_t      state;
	logic [addr_w-1:0] acc_addr; // access held for memory
	logic              write_done;
	logic              busy;
	logic              done_match;
	logic              start_read;
	logic              start_write;

	assign busy        = mem_req ^ mem_ack; // transfer outstanding
	assign done_match  = write_done && we && (addr == acc_addr);
	assign start_read  = (state == st_idle) && req && !we && !hit;
	assign start_write = (state == st_idle) && req && we && !done_match;

	always_comb begin
		if (state == st_idle) begin
			stall = req && (we ? !done_match : !hit);
		end else begin
			stall = 1'b1; // memory still working
		end
	end

	assign fill       = (state == st_fill) && !busy;
	assign fill_index = addr_index(acc_addr);
	assign fill_tag   = addr_tag(acc_addr);
	assign fill_word  = addr_word(acc_addr);

	// fills take over the one write port
	assign wr_en    = fill || (start_write && hit);
	assign wr_index = fill ? fill_index : addr_index(addr);
	assign wr_word  = fill ? fill_word : addr_word(addr);
	assign wr_data  = fill ? mem_rdata : wdata;

	assign mem_addr = acc_addr;

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= st_idle;
			mem_req    <= 1'b0;
			mem_we     <= 1'b0;
			write_done <= 1'b0;
		end else begin
			if (write_done && (!req || (addr != acc_addr))) begin
				write_done <= 1'b0; // processor moved on
			end
			case (state)
				st_idle: begin
					if (start_read || start_write) begin
						mem_req <= ~mem_req;
						mem_we  <= we;
						state   <= we ? st_write : st_fill;
					end
				end
				st_fill: begin
					if (!busy) begin
						state <= st_idle; // word installed this edge
					end
				end
				st_write: begin
					if (!busy) begin
						state      <= st_idle;
						write_done <= 1'b1;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start_read || start_write) begin
			acc_addr  <= addr;
			mem_wdata <= wdata;
		end
	end

	a_toggle_when_free: assert property (@(posedge clk) disable iff (rst)
		$changed(mem_req) |-> $past(mem_req) == $past(mem_ack))
		else $error("mem_req toggled while a transfer was outstanding");

	a_idle_after_ack: assert property (@(posedge clk) disable iff (rst)
		(state != st_idle) |-> busy || $past(busy))
		else $error("controller stayed busy after memory acknowledged");

endmodule

// File: hw/word_memory.sv
`timescale 1ns/1ps

module word_memory #(
	parameter int mem_latency = 3,
	parameter int mem_words   = 1024
) (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         mem_req,
	input  logic                         mem_we,
	input  logic [cache_pkg::addr_w-1:0] mem_addr,
	input  logic [cache_pkg::data_w-1:0] mem_wdata,
	output logic                         mem_ack,
	output logic [cache_pkg::data_w-1:0] mem_rdata
);
	import cache_pkg::*;

	localparam int word_addr_w = $clog2(mem_words);
	localparam int cnt_w       = $clog2(mem_latency + 1);

	logic [data_w-1:0]      mem [mem_words];
	logic [cnt_w-1:0]       count; // cycles spent on current request
	logic                   pending;
	logic                   respond;
	logic [word_addr_w-1:0] word_addr;

	assign pending   = mem_req ^ mem_ack;
	assign respond   = pending && (count == cnt_w'(mem_latency - 1));
	assign word_addr = mem_addr[byte_off_w +: word_addr_w]; // drop byte offset

	always_ff @(posedge clk) begin
		if (rst) begin
			count   <= '0;
			mem_ack <= 1'b0;
		end else if (respond) begin
			count   <= '0;
			mem_ack <= ~mem_ack;
		end else if (pending) begin
			count <= count + 1'b1;
		end
	end

	// access lands on the same edge as the ack toggle
	always_ff @(posedge clk) begin
		if (respond && mem_we) begin
			mem[word_addr] <= mem_wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (respond && !mem_we) begin
			mem_rdata <= mem[word_addr]; // held until next read
		end
	end

	a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
		$changed(mem_ack) |-> $past(pending, mem_latency))
		else $error("mem_ack toggled without a request pending for the full latency");

endmodule

// File: hw/cache_system.sv
`timescale 1ns/1ps

module cache_system #(
	parameter int mem_latency = 3,
	parameter int mem_words   = 1024
) (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         req,
	input  logic                         we,
	input  logic [cache_pkg::addr_w-1:0] addr,
	input  logic [cache_pkg::data_w-1:0] wdata,
	output logic [cache_pkg::data_w-1:0] rdata,
	output logic                         stall
);
	import cache_pkg::*;

	logic                  hit;
	logic                  fill;
	logic [index_w-1:0]    fill_index;
	logic [tag_w-1:0]      fill_tag;
	logic [word_sel_w-1:0] fill_word;
	logic                  wr_en;
	logic [index_w-1:0]    wr_index;
	logic [word_sel_w-1:0] wr_word;
	logic [data_w-1:0]     wr_data;
	logic                  mem_req;
	logic                  mem_we;
	logic [addr_w-1:0]     mem_addr;
	logic [data_w-1:0]     mem_wdata;
	logic                  mem_ack;
	logic [data_w-1:0]     mem_rdata;

	cache_ctrl u_ctrl (
		.clk        (clk),
		.rst        (rst),
		.req        (req),
		.we         (we),
		.addr       (addr),
		.wdata      (wdata),
		.hit        (hit),
		.stall      (stall),
		.fill       (fill),
		.fill_index (fill_index),
		.fill_tag   (fill_tag),
		.fill_word  (fill_word),
		.wr_en      (wr_en),
		.wr_index   (wr_index),
		.wr_word    (wr_word),
		.wr_data    (wr_data),
		.mem_req    (mem_req),
		.mem_we     (mem_we),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.mem_ack    (mem_ack),
		.mem_rdata  (mem_rdata)
	);

	cache_tag_store u_tags (
		.clk          (clk),
		.rst          (rst),
		.lookup_index (addr_index(addr)),
		.lookup_tag   (addr_tag(addr)),
		.lookup_word  (addr_word(addr)),
		.hit          (hit),
		.fill         (fill),
		.fill_index   (fill_index),
		.fill_tag     (fill_tag),
		.fill_word    (fill_word)
	);

	cache_data_store u_data (
		.clk      (clk),
		.rd_index (addr_index(addr)),
		.rd_word  (addr_word(addr)),
		.rdata    (rdata),
		.wr_en    (wr_en),
		.wr_index (wr_index),
		.wr_word  (wr_word),
		.wr_data  (wr_data)
	);

	word_memory #(
		.mem_latency (mem_latency),
		.mem_words   (mem_words)
	) u_mem (
		.clk       (clk),
		.rst       (rst),
		.mem_req   (mem_req),
		.mem_we    (mem_we),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_ack   (mem_ack),
		.mem_rdata (mem_rdata)
	);

endmodule

// File: bench/cache_system_tb.sv
`timescale 1ns/1ps

module cache_system_tb;
	import cache_pkg::*;

	localparam int mem_latency = 3;
	localparam int mem_words = 1024;
	localparam int clk_half = 5;
	localparam int access_limit = mem_latency + 8; // cycles before an access counts as hung
	localparam string input_file = "bench/cache_input.txt";

	logic              clk;
	logic              rst;
	logic              req;
	logic              we;
	logic [addr_w-1:0] addr;
	logic [data_w-1:0] wdata;
	logic [data_w-1:0] rdata;
	logic              stall;

	string             op_q [$];
	logic [addr_w-1:0] addr_q [$];
	logic [data_w-1:0] wdata_q [$];
	logic [data_w-1:0] rdata_q [$];
	bit                hit_q [$];
	int                line_q [$];

	int errors;
	int checks;
	int line_count;
	bit loaded;

	cache_system #(
		.mem_latency (mem_latency),
		.mem_words   (mem_words)
	) uut (
		.clk   (clk),
		.rst   (rst),
		.req   (req),
		.we    (we),
		.addr  (addr),
		.wdata (wdata),
		.rdata (rdata),
		.stall (stall)
	);

	initial begin
		clk = 1'b0;
		forever #clk_half clk = ~clk;
	end

	task automatic load_tests(output bit ok);
		int                fd;
		int                lineno;
		int                fields;
		int                h;
		string             line;
		string             op;
		logic [addr_w-1:0] a;
		logic [data_w-1:0] wd;
		logic [data_w-1:0] rd;
		ok = 1'b1;
		lineno = 0;
		fd = $fopen(input_file, "r");
		if (fd == 0) begin
			$display("cannot open stimulus file %s", input_file);
			ok = 1'b0;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			if ($fgets(line, fd) == 0) begin
				continue;
			end
			lineno++;
			if (line.len() < 2 || line[0] == "#") begin
				continue; // blank or column notes
			end
			fields = $sscanf(line, "%s %h %h %h %d", op, a, wd, rd, h);
			if (fields != 5 || (op != "rd" && op != "wr")) begin
				$display("unreadable stimulus at line %0d of %s", lineno, input_file);
				ok = 1'b0;
				continue;
			end
			op_q.push_back(op);
			addr_q.push_back(a);
			wdata_q.push_back(wd);
			rdata_q.push_back(rd);
			hit_q.push_back(h != 0);
			line_q.push_back(lineno);
		end
		$fclose(fd);
	endtask

	task automatic apply_reset();
		rst = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		@(negedge clk);
		checks++;
		assert (!stall) else begin
			$display("stall is high after reset although req is low");
			errors++;
		end
	endtask

	task automatic run_access(input int idx);
		string name;
		logic  first_hit;
		int    waited;
		name = $sformatf("line %0d %s %03h", line_q[idx], op_q[idx], addr_q[idx]);
		@(posedge clk);
		#1;
		req = 1'b1;
		we = (op_q[idx] == "wr");
		addr = addr_q[idx];
		wdata = wdata_q[idx];
		@(negedge clk);
		first_hit = !stall; // no stall in the first cycle means a hit
		waited = 0;
		while (stall && waited < access_limit) begin
			@(negedge clk);
			waited++;
		end
		checks++;
		assert (!stall) else begin
			$display("%s never completed, stall stayed high", name);
			errors++;
		end
		checks++;
		assert (first_hit == hit_q[idx]) else begin
			$display("[FAIL] %s hit: expected %0d, actual %0d", name, hit_q[idx], first_hit);
			errors++;
		end
		if (!we) begin
			checks++;
			assert (rdata == rdata_q[idx]) else begin
				$display("[FAIL] %s rdata: expected %h, actual %h", name, rdata_q[idx], rdata);
				errors++;
			end
		end
		@(posedge clk);
		#1;
		req = 1'b0;
		@(negedge clk);
		checks++;
		assert (!stall) else begin
			$display("%s left stall high after req dropped", name);
			errors++;
		end
	endtask

	initial begin
		bit ok;
		rst = 1'b1;
		req = 1'b0;
		we = 1'b0;
		addr = '0;
		wdata = '0;
		errors = 0;
		checks = 0;
		loaded = 1'b0;
		load_tests(ok);
		line_count = addr_q.size();
		loaded = 1'b1;
		apply_reset();
		if (!ok || line_count == 0) begin
			$display("stimulus file could not be used, no accesses were run");
			errors++;
		end else begin
			foreach (addr_q[i]) begin
				run_access(i);
			end
		end
		repeat (2) @(posedge clk);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	// bound on the whole run, scaled by the number of accesses
	initial begin
		wait (loaded);
		repeat (line_count * (mem_latency + 6) + 100) @(posedge clk);
		$display("watchdog expired, the accesses did not finish in time");
		$display("Regression failed");
		$finish;
	end

endmodule

// File: cache_system.f
hw/cache_pkg.sv
hw/cache_tag_store.sv
hw/cache_data_store.sv
hw/cache_ctrl.sv
hw/word_memory.sv
hw/cache_system.sv
bench/cache_system_tb.sv

// File: Makefile
# Verilator build and run for the cache system testbench

VERILATOR ?= verilator
TOP       ?= cache_system_tb
FILELIST  ?= cache_system.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: simulate clean

# the run passes only if the log holds the pass line
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/cache_input.txt
# columns: op (rd/wr), byte address (hex), write data (hex), expected read data (hex),
# expected hit (1 = stall low in the first cycle; writes always stall, so 0)
wr 230 11110000 00000000 0
rd 230 00000000 11110000 0
rd 230 00000000 11110000 1
wr 234 22220001 00000000 0
rd 234 00000000 22220001 0
rd 234 00000000 22220001 1
wr 230 33330002 00000000 0
rd 230 00000000 33330002 1
wr 290 44440003 00000000 0
rd 290 00000000 44440003 0
rd 290 00000000 44440003 1
rd 230 00000000 33330002 0
rd 234 00000000 22220001 0
rd 290 00000000 44440003 0
wr 290 55550004 00000000 0
rd 290 00000000 55550004 1
wr bfc deadbeef 00000000 0
rd bfc 00000000 deadbeef 0
rd bfc 00000000 deadbeef 1
wr 008 0badf00d 00000000 0
rd 008 00000000 0badf00d 0
wr e14 a5a5a5a5 00000000 0
rd e14 00000000 a5a5a5a5 0
rd 008 00000000 0badf00d 1
rd 290 00000000 55550004 1
rd bfc 00000000 deadbeef 1
wr e14 5a5a5a5a 00000000 0
rd e14 00000000 5a5a5a5a 1
